// File: source/biu_pkg.sv
package biu_pkg;

   ////////////////////////////////////////////////////////////////////
   // axi ids per requester
   ////////////////////////////////////////////////////////////////////

   localparam logic [3:0] AXI_RID_IFU = 4'd0;
   localparam logic [3:0] AXI_RID_LSU = 4'd1;
   localparam logic [3:0] AXI_WID_LSU = 4'd1;

   // single-beat word transfers only
   localparam logic [7:0] AXI_LEN_SINGLE = 8'd0;
   localparam logic [2:0] AXI_SIZE_WORD  = 3'd2;
   localparam logic [1:0] AXI_RESP_OKAY  = 2'b00;

   // lsu opcode
   typedef enum logic {
      LSU_LOAD  = 1'b0,
      LSU_STORE = 1'b1
   } lsu_cmd_e;

   typedef enum logic [1:0] {
      BURST_FIXED = 2'b00,
      BURST_INCR  = 2'b01,
      BURST_WRAP  = 2'b10
   } axi_burst_e;

   // ar / aw payload, 57 bits
   typedef struct packed {
      logic [3:0]  id;
      logic [31:0] addr;
      logic [7:0]  len;
      logic [2:0]  size;
      axi_burst_e  burst;
      logic        lock;
      logic [3:0]  cache;
      logic [2:0]  prot;
   } axi_addr_req_t;

   // w payload, 41 bits
   typedef struct packed {
      logic [3:0]  id;
      logic [31:0] data;
      logic [3:0]  strb;
      logic        last;
   } axi_wdata_t;

endpackage

// File: source/axi_req_slice.sv
`timescale 1ns/1ns

module axi_req_slice #(
   parameter int WIDTH = 57
) (
   input  logic             clk,
   input  logic             rst_n,

   // request side
   input  logic             in_val,
   input  logic [WIDTH-1:0] in_data,
   output logic             in_ready,

   // axi side
   input  logic             ext_ready,
   output logic             ext_valid,
   output logic [WIDTH-1:0] ext_data
);

   logic             valid_q;
   logic [WIDTH-1:0] data_q;
   logic             load;

   // busy only while an unaccepted request sits here
   assign in_ready = ~valid_q | ext_ready;
   assign load     = in_val & in_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= (valid_q & ~ext_ready) | load;
      end
   end

   // payload, no reset needed
   always_ff @(posedge clk) begin
      if (load) begin
         data_q <= in_data;
      end
   end

   assign ext_valid = valid_q;
   assign ext_data  = data_q;

endmodule

// File: source/biu_axi_interface.sv
`timescale 1ns/1ns

module biu_axi_interface (
   input  logic                   clk,
   input  logic                   rst_n,

   // arbitrated read request
   input  logic                   arb_rd_val,
   input  biu_pkg::axi_addr_req_t arb_rd,
   output logic                   axi_ar_ready,

   // write request from the store sequencer
   input  logic                   arb_aw_val,
   input  biu_pkg::axi_addr_req_t arb_aw,
   output logic                   axi_aw_ready,
   input  logic                   arb_w_val,
   input  biu_pkg::axi_wdata_t    arb_w,
   output logic                   axi_w_ready,

   // axi read address
   output logic                   ar_valid,
   input  logic                   ar_ready,
   output biu_pkg::axi_addr_req_t ar_req,

   // axi read data
   input  logic                   r_valid,
   output logic                   r_ready,
   input  logic [3:0]             r_id,
   input  logic [31:0]            r_data,
   input  logic                   r_last,
   input  logic [1:0]             r_resp,

   // axi write address and data
   output logic                   aw_valid,
   input  logic                   aw_ready,
   output biu_pkg::axi_addr_req_t aw_req,
   output logic                   w_valid,
   input  logic                   w_ready,
   output biu_pkg::axi_wdata_t    w_beat,

   // axi write response
   input  logic                   b_valid,
   output logic                   b_ready,
   input  logic [3:0]             b_id,
   input  logic [1:0]             b_resp,

   // completions toward the requesters
   output logic [31:0]            axi_rdata,
   output logic                   axi_rdata_ifu_val,
   output logic                   axi_rdata_lsu_val,
   output logic                   axi_write_lsu_val
);

   localparam int ADDR_W = $bits(biu_pkg::axi_addr_req_t);
   localparam int WDATA_W = $bits(biu_pkg::axi_wdata_t);

   logic r_fin;
   logic rdata_val;
   logic b_fin;

   ////////////////////////////////////////////////////////////////////
   // request channels, each held until the slave takes it
   ////////////////////////////////////////////////////////////////////

   axi_req_slice #(.WIDTH(ADDR_W)) ar_slice (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_val    (arb_rd_val),
      .in_data   (arb_rd),
      .in_ready  (axi_ar_ready),
      .ext_ready (ar_ready),
      .ext_valid (ar_valid),
      .ext_data  (ar_req)
   );

   axi_req_slice #(.WIDTH(ADDR_W)) aw_slice (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_val    (arb_aw_val),
      .in_data   (arb_aw),
      .in_ready  (axi_aw_ready),
      .ext_ready (aw_ready),
      .ext_valid (aw_valid),
      .ext_data  (aw_req)
   );

   axi_req_slice #(.WIDTH(WDATA_W)) w_slice (
      .clk       (clk),
      .rst_n     (rst_n),
      .in_val    (arb_w_val),
      .in_data   (arb_w),
      .in_ready  (axi_w_ready),
      .ext_ready (w_ready),
      .ext_valid (w_valid),
      .ext_data  (w_beat)
   );

   ////////////////////////////////////////////////////////////////////
   // read data, steered by rid
   ////////////////////////////////////////////////////////////////////

   assign r_ready = 1'b1;
   assign r_fin   = r_valid & r_ready;

   // error responses drop the strobe
   assign rdata_val = r_fin & r_last & (r_resp == biu_pkg::AXI_RESP_OKAY);

   assign axi_rdata_ifu_val = rdata_val & (r_id == biu_pkg::AXI_RID_IFU);
   assign axi_rdata_lsu_val = rdata_val & (r_id == biu_pkg::AXI_RID_LSU);
   assign axi_rdata         = r_data;

   // write response, bresp not checked
   assign b_ready           = 1'b1;
   assign b_fin             = b_valid & b_ready;
   assign axi_write_lsu_val = b_fin & (b_id == biu_pkg::AXI_WID_LSU);

endmodule

// File: source/biu_rd_arbiter.sv
`timescale 1ns/1ns

module biu_rd_arbiter #(
   parameter bit LSU_FIRST = 1'b1
) (
   input  logic                   clk,
   input  logic                   rst_n,

   input  logic                   ifu_req,
   input  logic [31:0]            ifu_addr,
   input  logic                   lsu_rd_req,
   input  logic [31:0]            lsu_addr,

   input  logic                   axi_ar_ready,
   output logic                   arb_rd_val,
   output biu_pkg::axi_addr_req_t arb_rd
);

   // same cache attributes for both sources
   localparam logic [3:0] RD_CACHE = 4'b0011;
   // ifu prot marks instruction access
   localparam logic [2:0] IFU_PROT = 3'b100;
   localparam logic [2:0] LSU_PROT = 3'b000;

   logic        ifu_pend;
   logic        lsu_pend;
   logic [31:0] ifu_addr_q;
   logic [31:0] lsu_addr_q;
   logic        sel_lsu;

   // lsu wins a tie only with LSU_FIRST set
   assign sel_lsu    = lsu_pend & (~ifu_pend | LSU_FIRST);
   assign arb_rd_val = (ifu_pend | lsu_pend) & axi_ar_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ifu_pend <= 1'b0;
         lsu_pend <= 1'b0;
      end else begin
         if (ifu_req)
            ifu_pend <= 1'b1;
         else if (arb_rd_val && !sel_lsu)
            ifu_pend <= 1'b0;
         if (lsu_rd_req)
            lsu_pend <= 1'b1;
         else if (arb_rd_val && sel_lsu)
            lsu_pend <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ifu_req)
         ifu_addr_q <= ifu_addr;
      if (lsu_rd_req)
         lsu_addr_q <= lsu_addr;
   end

   always_comb begin
      arb_rd.id    = sel_lsu ? biu_pkg::AXI_RID_LSU : biu_pkg::AXI_RID_IFU;
      arb_rd.addr  = sel_lsu ? lsu_addr_q : ifu_addr_q;
      arb_rd.len   = biu_pkg::AXI_LEN_SINGLE;
      arb_rd.size  = biu_pkg::AXI_SIZE_WORD;
      arb_rd.burst = biu_pkg::BURST_INCR;
      arb_rd.lock  = 1'b0;
      arb_rd.cache = RD_CACHE;
      arb_rd.prot  = sel_lsu ? LSU_PROT : IFU_PROT;
   end

endmodule

// File: source/biu_wr_issue.sv
`timescale 1ns/1ns

module biu_wr_issue (
   input  logic                   clk,
   input  logic                   rst_n,

   // store request
   input  logic                   lsu_wr_req,
   input  logic [31:0]            lsu_addr,
   input  logic [31:0]            lsu_wdata,
   input  logic [3:0]             lsu_strb,

   // toward the axi interface
   input  logic                   axi_aw_ready,
   input  logic                   axi_w_ready,
   input  logic                   axi_write_lsu_val,
   output logic                   arb_aw_val,
   output biu_pkg::axi_addr_req_t arb_aw,
   output logic                   arb_w_val,
   output biu_pkg::axi_wdata_t    arb_w,

   output logic                   lsu_wr_done
);

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_SEND,
      WR_RESP
   } wr_state_e;

   wr_state_e   state;
   logic        aw_sent;
   logic        w_sent;
   logic [31:0] addr_q;
   logic [31:0] wdata_q;
   logic [3:0]  strb_q;
   logic        all_sent;

   // aw and w go independently, either may lead
   assign arb_aw_val  = (state == WR_SEND) & ~aw_sent & axi_aw_ready;
   assign arb_w_val   = (state == WR_SEND) & ~w_sent & axi_w_ready;
   assign all_sent    = (aw_sent | arb_aw_val) & (w_sent | arb_w_val);
   assign lsu_wr_done = (state == WR_RESP) & axi_write_lsu_val;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state   <= WR_IDLE;
         aw_sent <= 1'b0;
         w_sent  <= 1'b0;
      end else begin
         case (state)
            WR_IDLE: begin
               if (lsu_wr_req)
                  state <= WR_SEND;
            end
            WR_SEND: begin
               if (all_sent) begin
                  state   <= WR_RESP;
                  aw_sent <= 1'b0;
                  w_sent  <= 1'b0;
               end else begin
                  aw_sent <= aw_sent | arb_aw_val;
                  w_sent  <= w_sent | arb_w_val;
               end
            end
            WR_RESP: begin
               if (axi_write_lsu_val)
                  state <= WR_IDLE;
            end
            default: state <= WR_IDLE;
         endcase
      end
   end

   // store payload
   always_ff @(posedge clk) begin
      if (state == WR_IDLE && lsu_wr_req) begin
         addr_q  <= lsu_addr;
         wdata_q <= lsu_wdata;
         strb_q  <= lsu_strb;
      end
   end

   always_comb begin
      arb_aw.id    = biu_pkg::AXI_WID_LSU;
      arb_aw.addr  = addr_q;
      arb_aw.len   = biu_pkg::AXI_LEN_SINGLE;
      arb_aw.size  = biu_pkg::AXI_SIZE_WORD;
      arb_aw.burst = biu_pkg::BURST_INCR;
      arb_aw.lock  = 1'b0;
      arb_aw.cache = 4'b0011;
      arb_aw.prot  = 3'b000;
      arb_w.id     = biu_pkg::AXI_WID_LSU;
      arb_w.data   = wdata_q;
      arb_w.strb   = strb_q;
      arb_w.last   = 1'b1;
   end

endmodule

// File: source/biu_top.sv
`timescale 1ns/1ns

module biu_top #(
   parameter bit LSU_FIRST = 1'b1
) (
   input  logic                   clk,
   input  logic                   rst_n,

   // fetch and load/store requests
   input  logic                   ifu_req,
   input  logic [31:0]            ifu_addr,
   input  logic                   lsu_req,
   input  biu_pkg::lsu_cmd_e      lsu_cmd,
   input  logic [31:0]            lsu_addr,
   input  logic [31:0]            lsu_wdata,
   input  logic [3:0]             lsu_strb,

   // axi master
   output logic                   ar_valid,
   input  logic                   ar_ready,
   output biu_pkg::axi_addr_req_t ar_req,
   input  logic                   r_valid,
   output logic                   r_ready,
   input  logic [3:0]             r_id,
   input  logic [31:0]            r_data,
   input  logic                   r_last,
   input  logic [1:0]             r_resp,
   output logic                   aw_valid,
   input  logic                   aw_ready,
   output biu_pkg::axi_addr_req_t aw_req,
   output logic                   w_valid,
   input  logic                   w_ready,
   output biu_pkg::axi_wdata_t    w_beat,
   input  logic                   b_valid,
   output logic                   b_ready,
   input  logic [3:0]             b_id,
   input  logic [1:0]             b_resp,

   // completions
   output logic                   ifu_rdata_val,
   output logic                   lsu_rdata_val,
   output logic [31:0]            rdata,
   output logic                   lsu_wr_done
);

   logic                   lsu_rd_req;
   logic                   lsu_wr_req;
   logic                   arb_rd_val;
   biu_pkg::axi_addr_req_t arb_rd;
   logic                   axi_ar_ready;
   logic                   arb_aw_val;
   biu_pkg::axi_addr_req_t arb_aw;
   logic                   axi_aw_ready;
   logic                   arb_w_val;
   biu_pkg::axi_wdata_t    arb_w;
   logic                   axi_w_ready;
   logic                   axi_write_lsu_val;

   // loads to the read arbiter, stores to the write sequencer
   assign lsu_rd_req = lsu_req & (lsu_cmd == biu_pkg::LSU_LOAD);
   assign lsu_wr_req = lsu_req & (lsu_cmd == biu_pkg::LSU_STORE);

   biu_rd_arbiter #(.LSU_FIRST(LSU_FIRST)) rd_arb0 (
      .clk (clk), .rst_n (rst_n),
      .ifu_req (ifu_req), .ifu_addr (ifu_addr),
      .lsu_rd_req (lsu_rd_req), .lsu_addr (lsu_addr),
      .axi_ar_ready (axi_ar_ready), .arb_rd_val (arb_rd_val), .arb_rd (arb_rd)
   );

   biu_wr_issue wr_issue0 (
      .clk (clk), .rst_n (rst_n),
      .lsu_wr_req (lsu_wr_req), .lsu_addr (lsu_addr),
      .lsu_wdata (lsu_wdata), .lsu_strb (lsu_strb),
      .axi_aw_ready (axi_aw_ready), .axi_w_ready (axi_w_ready),
      .axi_write_lsu_val (axi_write_lsu_val),
      .arb_aw_val (arb_aw_val), .arb_aw (arb_aw),
      .arb_w_val (arb_w_val), .arb_w (arb_w),
      .lsu_wr_done (lsu_wr_done)
   );

   biu_axi_interface axi_if0 (
      .clk (clk), .rst_n (rst_n),
      .arb_rd_val (arb_rd_val), .arb_rd (arb_rd), .axi_ar_ready (axi_ar_ready),
      .arb_aw_val (arb_aw_val), .arb_aw (arb_aw), .axi_aw_ready (axi_aw_ready),
      .arb_w_val (arb_w_val), .arb_w (arb_w), .axi_w_ready (axi_w_ready),
      .ar_valid (ar_valid), .ar_ready (ar_ready), .ar_req (ar_req),
      .r_valid (r_valid), .r_ready (r_ready), .r_id (r_id),
      .r_data (r_data), .r_last (r_last), .r_resp (r_resp),
      .aw_valid (aw_valid), .aw_ready (aw_ready), .aw_req (aw_req),
      .w_valid (w_valid), .w_ready (w_ready), .w_beat (w_beat),
      .b_valid (b_valid), .b_ready (b_ready), .b_id (b_id), .b_resp (b_resp),
      .axi_rdata (rdata),
      .axi_rdata_ifu_val (ifu_rdata_val),
      .axi_rdata_lsu_val (lsu_rdata_val),
      .axi_write_lsu_val (axi_write_lsu_val)
   );

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int PERIOD = 8
) (
   output logic clk
);

   logic clk_q = 1'b0;

   always #(PERIOD / 2) clk_q = ~clk_q;

   assign clk = clk_q;

endmodule

// File: tests/biu_checker.sv
`timescale 1ns/1ns

module biu_checker (
   input logic                   clk,
   input logic                   rst_n,
   input logic                   arb_rd_val,
   input biu_pkg::axi_addr_req_t arb_rd,
   input logic                   arb_aw_val,
   input biu_pkg::axi_addr_req_t arb_aw,
   input logic                   arb_w_val,
   input biu_pkg::axi_wdata_t    arb_w,
   input logic                   ar_valid,
   input logic                   ar_ready,
   input biu_pkg::axi_addr_req_t ar_req,
   input logic                   aw_valid,
   input logic                   aw_ready,
   input biu_pkg::axi_addr_req_t aw_req,
   input logic                   w_valid,
   input logic                   w_ready,
   input biu_pkg::axi_wdata_t    w_beat
);

   // a pushed request lands in its slice and is on the bus next cycle
   rd_legal: assert property (@(posedge clk) disable iff (!rst_n)
      arb_rd_val |=> ar_valid && ar_req == $past(arb_rd))
      else $error("read request pushed but not presented on the AR channel");
   aw_legal: assert property (@(posedge clk) disable iff (!rst_n)
      arb_aw_val |=> aw_valid && aw_req == $past(arb_aw))
      else $error("write address pushed but not presented on the AW channel");
   w_legal: assert property (@(posedge clk) disable iff (!rst_n)
      arb_w_val |=> w_valid && w_beat == $past(arb_w))
      else $error("write data pushed but not presented on the W channel");

   // axi valid/ready rule
   ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
      ar_valid && !ar_ready |=> ar_valid && $stable(ar_req))
      else $error("AR request dropped or changed before ar_ready");
   aw_hold: assert property (@(posedge clk) disable iff (!rst_n)
      aw_valid && !aw_ready |=> aw_valid)
      else $error("aw_valid dropped before aw_ready");
   w_hold: assert property (@(posedge clk) disable iff (!rst_n)
      w_valid && !w_ready |=> w_valid)
      else $error("w_valid dropped before w_ready");

   reset_quiet: assert property (@(posedge clk) !rst_n |=>
      !(ar_valid || aw_valid || w_valid || arb_rd_val || arb_aw_val || arb_w_val))
      else $error("valid high in the cycle after reset");

endmodule

bind biu_axi_interface biu_checker chk0 (.*);

// File: tests/biu_tb.sv
`timescale 1ns/1ns

module biu_tb;

   localparam int MAX_TXN        = 300;
   localparam int CYC_PER_TXN    = 30;
   localparam int TIMEOUT_CYCLES = MAX_TXN * CYC_PER_TXN;
   localparam int N_RANDOM       = 150;

   logic                   clk;
   logic                   rst_n = 1'b0;
   logic                   ifu_req = 1'b0;
   logic [31:0]            ifu_addr = '0;
   logic                   lsu_req = 1'b0;
   biu_pkg::lsu_cmd_e      lsu_cmd = biu_pkg::LSU_LOAD;
   logic [31:0]            lsu_addr = '0;
   logic [31:0]            lsu_wdata = '0;
   logic [3:0]             lsu_strb = '0;
   logic                   ar_valid;
   logic                   ar_ready = 1'b0;
   biu_pkg::axi_addr_req_t ar_req;
   logic                   r_valid = 1'b0;
   logic                   r_ready;
   logic [3:0]             r_id = '0;
   logic [31:0]            r_data = '0;
   logic                   r_last = 1'b0;
   logic [1:0]             r_resp = '0;
   logic                   aw_valid;
   logic                   aw_ready = 1'b0;
   biu_pkg::axi_addr_req_t aw_req;
   logic                   w_valid;
   logic                   w_ready = 1'b0;
   biu_pkg::axi_wdata_t    w_beat;
   logic                   b_valid = 1'b0;
   logic                   b_ready;
   logic [3:0]             b_id = '0;
   logic [1:0]             b_resp = '0;
   logic                   ifu_rdata_val;
   logic                   lsu_rdata_val;
   logic [31:0]            rdata;
   logic                   lsu_wr_done;

   integer      seed = 32'h4ef1_a502;
   integer      slave_seed = 32'h4ef1_a502;
   logic [31:0] ref_mem [logic [31:0]];
   logic [31:0] slave_mem [logic [31:0]];
   logic [31:0] rq_addr [$];
   logic [3:0]  rq_id [$];
   logic [3:0]  ar_ids [$];
   logic [31:0] wq_addr [$];
   logic [31:0] wq_data [$];
   logic [3:0]  wq_strb [$];
   logic [31:0] ifu_exp_addr = '0;
   logic [31:0] lsu_exp_addr = '0;
   int          ifu_issued = 0;
   int          ifu_done = 0;
   int          lsu_issued = 0;
   int          lsu_done = 0;
   int          st_issued = 0;
   int          st_done = 0;
   int          st_total = 0;
   int          rd_total = 0;
   int          aw_cnt = 0;
   int          w_cnt = 0;
   int          err_cnt = 0;
   int          r_wait = 0;
   int          b_wait = 0;
   int          cycles = 0;

   tb_clock_gen #(.PERIOD(8)) clk_gen0 (.clk(clk));

   biu_top #(.LSU_FIRST(1'b1)) dut0 (.*);

   //////////////////////////////////////////////////////////////////////
   // reference model
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] init_word(input logic [31:0] a);
      return a ^ 32'h5a5a_0000;
   endfunction

   function automatic logic [31:0] merge_word(input logic [31:0] old, input logic [31:0] d,
                                              input logic [3:0] s);
      logic [31:0] w;
      w = old;
      for (int i = 0; i < 4; i++) begin
         if (s[i])
            w[8*i +: 8] = d[8*i +: 8];
      end
      return w;
   endfunction

   function automatic logic [31:0] ref_read(input logic [31:0] a);
      return ref_mem.exists(a) ? ref_mem[a] : init_word(a);
   endfunction

   function automatic logic [31:0] slave_read(input logic [31:0] a);
      return slave_mem.exists(a) ? slave_mem[a] : init_word(a);
   endfunction

   task automatic stop_on_error();
      $display("Checks failed");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, exp);
         stop_on_error();
      end
   endtask

   //////////////////////////////////////////////////////////////////////
   // axi slave, random stalls, in-order responses
   //////////////////////////////////////////////////////////////////////

   always @(posedge clk) begin
      if (rst_n) begin
         ar_ready <= ($random(slave_seed) & 3) != 0;
         aw_ready <= ($random(slave_seed) & 3) != 0;
         w_ready  <= ($random(slave_seed) & 3) != 0;
         // responses last one cycle, so ready has to be up with valid
         if (r_valid)
            check("r_ready", 32'(r_ready), 32'(1'b1));
         if (b_valid)
            check("b_ready", 32'(b_ready), 32'(1'b1));
         if (ar_valid && ar_ready) begin
            check("ar_req.addr", ar_req.addr,
                  (ar_req.id == biu_pkg::AXI_RID_LSU) ? lsu_exp_addr : ifu_exp_addr);
            ar_ids.push_back(ar_req.id);
            rq_id.push_back(ar_req.id);
            rq_addr.push_back(ar_req.addr);
         end
         r_valid <= 1'b0;
         if (rq_id.size() != 0) begin
            if (r_wait == 0) begin
               // top nibble f marks the error region
               r_valid <= 1'b1;
               r_id    <= rq_id[0];
               r_data  <= slave_read(rq_addr[0]);
               r_last  <= 1'b1;
               r_resp  <= (rq_addr[0][31:28] == 4'hf) ? 2'b10 : 2'b00;
               if (rq_addr[0][31:28] == 4'hf)
                  err_cnt <= err_cnt + 1;
               void'(rq_id.pop_front());
               void'(rq_addr.pop_front());
               r_wait <= $random(slave_seed) & 3;
            end else begin
               r_wait <= r_wait - 1;
            end
         end
         if (aw_valid && aw_ready) begin
            check("aw_req.addr", aw_req.addr, lsu_addr);
            aw_cnt <= aw_cnt + 1;
            wq_addr.push_back(aw_req.addr);
         end
         if (w_valid && w_ready) begin
            check("w_beat.data", w_beat.data, lsu_wdata);
            check("w_beat.strb", 32'(w_beat.strb), 32'(lsu_strb));
            // single-beat writes
            check("w_beat.last", 32'(w_beat.last), 32'(1'b1));
            w_cnt <= w_cnt + 1;
            wq_data.push_back(w_beat.data);
            wq_strb.push_back(w_beat.strb);
         end
         b_valid <= 1'b0;
         if (wq_addr.size() != 0 && wq_data.size() != 0) begin
            if (b_wait == 0) begin
               slave_mem[wq_addr[0]] = merge_word(slave_read(wq_addr[0]), wq_data[0], wq_strb[0]);
               void'(wq_addr.pop_front());
               void'(wq_data.pop_front());
               void'(wq_strb.pop_front());
               b_valid <= 1'b1;
               b_id    <= biu_pkg::AXI_WID_LSU;
               b_resp  <= 2'b00;
               b_wait  <= $random(slave_seed) & 3;
            end else begin
               b_wait <= b_wait - 1;
            end
         end
      end
   end

   // compare completions against the reference model
   always @(posedge clk) begin
      if (rst_n) begin
         if (ifu_rdata_val) begin
            if (ifu_done == ifu_issued) begin
               $display("fetch data strobe seen with no fetch outstanding");
               stop_on_error();
            end
            check("rdata (fetch)", rdata, ref_read(ifu_exp_addr));
            ifu_done <= ifu_done + 1;
         end
         if (lsu_rdata_val) begin
            if (lsu_done == lsu_issued) begin
               $display("load data strobe seen with no load outstanding");
               stop_on_error();
            end
            check("rdata (load)", rdata, ref_read(lsu_exp_addr));
            lsu_done <= lsu_done + 1;
         end
         if (lsu_wr_done) begin
            if (st_done == st_issued) begin
               $display("lsu_wr_done seen with no store outstanding");
               stop_on_error();
            end
            st_done <= st_done + 1;
         end
      end
   end

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout, run did not end within %0d cycles", TIMEOUT_CYCLES);
         stop_on_error();
      end
   end

   //////////////////////////////////////////////////////////////////////
   // stimulus
   //////////////////////////////////////////////////////////////////////

   function automatic logic [31:0] rand_addr();
      return 32'h0000_1000 + (($random(seed) & 32'hff) << 2);
   endfunction

   task automatic issue_reads(input bit do_ifu, input logic [31:0] ia,
                              input bit do_lsu, input logic [31:0] la);
      int ifu_target;
      int lsu_target;
      ifu_target = ifu_done + int'(do_ifu);
      lsu_target = lsu_done + int'(do_lsu);
      @(posedge clk);
      ifu_req      <= do_ifu;
      ifu_addr     <= ia;
      ifu_exp_addr <= ia;
      lsu_req      <= do_lsu;
      lsu_cmd      <= biu_pkg::LSU_LOAD;
      lsu_addr     <= la;
      lsu_exp_addr <= la;
      ifu_issued   <= ifu_target;
      lsu_issued   <= lsu_target;
      rd_total = rd_total + int'(do_ifu) + int'(do_lsu);
      @(posedge clk);
      ifu_req <= 1'b0;
      lsu_req <= 1'b0;
      wait (ifu_done == ifu_target && lsu_done == lsu_target);
   endtask

   // lsu must win the first ar
   task automatic fetch_and_load(input logic [31:0] ia, input logic [31:0] la);
      int base;
      base = ar_ids.size();
      issue_reads(1'b1, ia, 1'b1, la);
      check("first ar id", 32'(ar_ids[base]), 32'(biu_pkg::AXI_RID_LSU));
   endtask

   task automatic store_word(input logic [31:0] a, input logic [31:0] d, input logic [3:0] s);
      int target;
      logic [31:0] old;
      target = st_done + 1;
      old = ref_read(a);
      @(posedge clk);
      lsu_req   <= 1'b1;
      lsu_cmd   <= biu_pkg::LSU_STORE;
      lsu_addr  <= a;
      lsu_wdata <= d;
      lsu_strb  <= s;
      st_issued <= target;
      @(posedge clk);
      lsu_req <= 1'b0;
      wait (st_done == target);
      ref_mem[a] = merge_word(old, d, s);
      st_total = st_total + 1;
      check("aw beats", aw_cnt, st_total);
      check("w beats", w_cnt, st_total);
   endtask

   // slverr read, then a normal read from the same source
   task automatic error_read(input bit to_lsu, input logic [31:0] a);
      int target;
      target = err_cnt + 1;
      @(posedge clk);
      if (to_lsu) begin
         lsu_req      <= 1'b1;
         lsu_cmd      <= biu_pkg::LSU_LOAD;
         lsu_addr     <= a;
         lsu_exp_addr <= a;
      end else begin
         ifu_req      <= 1'b1;
         ifu_addr     <= a;
         ifu_exp_addr <= a;
      end
      rd_total = rd_total + 1;
      @(posedge clk);
      ifu_req <= 1'b0;
      lsu_req <= 1'b0;
      wait (err_cnt == target);
      issue_reads(!to_lsu, a & 32'h0fff_ffff, to_lsu, a & 32'h0fff_ffff);
   endtask

   initial begin
      int op;
      logic [31:0] a;
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      issue_reads(1'b1, 32'h0000_1000, 1'b0, '0);
      issue_reads(1'b0, '0, 1'b1, 32'h0000_1004);
      store_word(32'h0000_1004, 32'ha5c3_7e19, 4'b0101);
      issue_reads(1'b0, '0, 1'b1, 32'h0000_1004);
      issue_reads(1'b1, 32'h0000_1004, 1'b0, '0);
      fetch_and_load(32'h0000_1008, 32'h0000_100c);
      error_read(1'b0, 32'hf000_1010);
      error_read(1'b1, 32'hf000_1014);
      for (int i = 0; i < N_RANDOM; i++) begin
         op = $random(seed) & 7;
         a = rand_addr();
         case (op)
            0, 1: issue_reads(1'b1, a, 1'b0, '0);
            2, 3: issue_reads(1'b0, '0, 1'b1, a);
            4, 5: store_word(a, $random(seed), 4'($random(seed)));
            6: fetch_and_load(a, a ^ 32'h4);
            default: error_read(i[0], a | 32'hf000_0000);
         endcase
      end
      repeat (4) @(posedge clk);
      check("ar beats", ar_ids.size(), rd_total);
      $display("All checks passed");
      $finish;
   end

endmodule

// File: all.f
source/biu_pkg.sv
source/axi_req_slice.sv
source/biu_axi_interface.sv
source/biu_rd_arbiter.sv
source/biu_wr_issue.sv
source/biu_top.sv
tests/tb_clock_gen.sv
tests/biu_checker.sv
tests/biu_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
   --top-module biu_tb \
   -f all.f \
   -o biu_sim

# the simulator exit code is ignored here, the log decides
./obj_dir/biu_sim 2>&1 | tee sim.log

if grep -q "^All checks passed$" sim.log; then
   echo "simulation PASSED"
else
   echo "simulation FAILED"
   exit 1
fi
